//--- hdl/rv64_consts.svh
`ifndef RV64_CONSTS_SVH
`define RV64_CONSTS_SVH

// ----------------------------------------
// Datapath sizes.
// ----------------------------------------

// Integer register and data word width.
`define XLEN        64

// Number of integer registers, x0 included.
`define NUM_REGS    32

// Register index width.
`define REG_ADDR_W  5

// Raw immediate field, instruction bits 31 down to 7.
`define IMM_FIELD_W 25

// ----------------------------------------
// RV64I major opcodes, bits 6:0.
// ----------------------------------------

// Memory access.
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011

// Control transfer.
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111

// Upper immediate forms.
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111

// Arithmetic, immediate and register forms.
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011

// CSR access and environment calls.
`define OPC_SYSTEM  7'b1110011

`endif

//--- hdl/rv64_isa_pkg.sv
`include "rv64_consts.svh"

package rv64_isa_pkg;

    // ----------------------------------------
    // Plain vector types.
    // ----------------------------------------

    // Integer data word.
    typedef logic [ `XLEN - 1:0 ] word_t;

    // Fetched instruction, always 32 bits.
    typedef logic [ 31:0 ] instr_t;

    // Register file index.
    typedef logic [ `REG_ADDR_W - 1:0 ] reg_addr_t;

    // Instruction bits 31:7 as one field.
    typedef logic [ `IMM_FIELD_W - 1:0 ] imm_field_t;

    // ----------------------------------------
    // Immediate layout select.
    // ----------------------------------------

    // Encodings 6 and 7 are unused.
    typedef enum logic [ 2:0 ] {
        IMM_I   = 3'd0,
        IMM_S   = 3'd1,
        IMM_B   = 3'd2,
        IMM_J   = 3'd3,
        IMM_U   = 3'd4,
        IMM_CSR = 3'd5
    } imm_fmt_t;

endpackage

//--- hdl/decode_ctrl_pkg.sv
package decode_ctrl_pkg;

    // Second ALU operand select.
    typedef enum logic {
        ALU_SRC_REG = 1'b0,
        ALU_SRC_IMM = 1'b1
    } alu_src_t;

    // Source of the value written back to rd.
    typedef enum logic [ 1:0 ] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2,
        RES_IMM = 2'd3
    } result_src_t;

    // Coarse ALU operation class.
    // Execute refines FUNCT with funct3 and funct7.
    typedef enum logic [ 1:0 ] {
        ALU_ADD     = 2'd0,
        ALU_SUB_CMP = 2'd1,
        ALU_FUNCT   = 2'd2,
        ALU_PASS    = 2'd3
    } alu_class_t;

endpackage

//--- hdl/extend_imm.sv
`timescale 1ns/1ns
`include "rv64_consts.svh"

module extend_imm
    import rv64_isa_pkg::*;
(
    // Layout select from the decoder.
    input  imm_fmt_t   i_imm_fmt,

    // Instruction bits 31:7.
    input  imm_field_t i_imm,

    // Extended immediate.
    output word_t      o_imm_ext
);

    // Field bit holding instruction bit 31.
    localparam int SIGN_BIT = `IMM_FIELD_W - 1;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_j;
    word_t imm_u;
    word_t imm_csr;

    // ----------------------------------------
    // Layouts, field bit k is instr bit k+7.
    // ----------------------------------------

    // I: instr[31:20].
    assign imm_i = { { (`XLEN - 12) { i_imm[ SIGN_BIT ] } }, i_imm[ 24:13 ] };

    // S: instr[31:25] and instr[11:7].
    assign imm_s = { { (`XLEN - 12) { i_imm[ SIGN_BIT ] } }, i_imm[ 24:18 ], i_imm[ 4:0 ] };

    // B: bit 11 sits at instr[7]; offset is even.
    assign imm_b = { { (`XLEN - 12) { i_imm[ SIGN_BIT ] } }, i_imm[ 0 ],
                     i_imm[ 23:18 ], i_imm[ 4:1 ], 1'b0 };

    // J: bit 20 comes from the sign fill.
    assign imm_j = { { (`XLEN - 20) { i_imm[ SIGN_BIT ] } }, i_imm[ 12:5 ],
                     i_imm[ 13 ], i_imm[ 23:14 ], 1'b0 };

    // U: instr[31:12] shifted up, upper word sign-filled.
    assign imm_u = { { (`XLEN - 32) { i_imm[ SIGN_BIT ] } }, i_imm[ 24:5 ], 12'b0 };

    // CSR uimm: instr[19:15], zero-filled.
    assign imm_csr = { { (`XLEN - 5) { 1'b0 } }, i_imm[ 12:8 ] };

    // Format mux; unused codes give zero.
    always_comb begin
        case ( i_imm_fmt )
            IMM_I:   o_imm_ext = imm_i;
            IMM_S:   o_imm_ext = imm_s;
            IMM_B:   o_imm_ext = imm_b;
            IMM_J:   o_imm_ext = imm_j;
            IMM_U:   o_imm_ext = imm_u;
            IMM_CSR: o_imm_ext = imm_csr;
            default: o_imm_ext = '0;
        endcase
    end

endmodule

//--- hdl/main_decoder.sv
`timescale 1ns/1ns
`include "rv64_consts.svh"

module main_decoder
    import rv64_isa_pkg::*;
    import decode_ctrl_pkg::*;
(
    // Instruction fields.
    input  logic [ 6:0 ] i_opcode,
    input  logic [ 2:0 ] i_funct3,

    // Immediate layout for the extender.
    output imm_fmt_t     o_imm_fmt,

    // Write and flow controls.
    output logic         o_reg_write,
    output logic         o_mem_write,
    output logic         o_branch,
    output logic         o_jump,

    // Execute controls.
    output alu_src_t     o_alu_src,
    output result_src_t  o_result_src,
    output alu_class_t   o_alu_class,

    // Unsupported encoding.
    output logic         o_illegal
);

    always_comb begin
        // Defaults, a harmless no-op.
        o_imm_fmt    = IMM_I;
        o_reg_write  = 1'b0;
        o_mem_write  = 1'b0;
        o_branch     = 1'b0;
        o_jump       = 1'b0;
        o_alu_src    = ALU_SRC_REG;
        o_result_src = RES_ALU;
        o_alu_class  = ALU_ADD;
        o_illegal    = 1'b0;

        case ( i_opcode )
            // ----------------------------------------
            // Memory access.
            // ----------------------------------------
            `OPC_LOAD: begin
                o_reg_write  = 1'b1;
                o_result_src = RES_MEM;
            end
            `OPC_STORE: begin
                o_imm_fmt   = IMM_S;
                o_mem_write = 1'b1;
            end

            // ----------------------------------------
            // Control transfer.
            // ----------------------------------------
            `OPC_BRANCH: begin
                o_imm_fmt   = IMM_B;
                o_branch    = 1'b1;
                o_alu_class = ALU_SUB_CMP;
            end
            `OPC_JAL: begin
                o_imm_fmt    = IMM_J;
                o_jump       = 1'b1;
                o_reg_write  = 1'b1;
                o_result_src = RES_PC4;
            end
            `OPC_JALR: begin
                // Target is rs1 plus the I immediate.
                o_jump       = 1'b1;
                o_reg_write  = 1'b1;
                o_result_src = RES_PC4;
            end

            // Upper immediates.
            `OPC_LUI: begin
                o_imm_fmt    = IMM_U;
                o_result_src = RES_IMM;
            end
            `OPC_AUIPC: begin
                o_imm_fmt = IMM_U;
            end

            // Arithmetic; funct3/funct7 resolved later.
            `OPC_OP_IMM: begin
                o_alu_class = ALU_FUNCT;
                o_alu_src   = ALU_SRC_IMM;
            end
            `OPC_OP: begin
                o_alu_class = ALU_FUNCT;
            end

            // CSR forms only; funct3 of zero is ecall/ebreak.
            `OPC_SYSTEM: begin
                if ( i_funct3 != 3'b000 ) begin
                    o_imm_fmt   = IMM_CSR;
                    o_reg_write = 1'b1;
                end else begin
                    o_illegal = 1'b1;
                end
            end

            // Unknown opcode.
            default: begin
                o_illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ns
`include "rv64_consts.svh"

module register_file
    import rv64_isa_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,

    // Write-back port.
    input  logic      i_we,
    input  reg_addr_t i_waddr,
    input  word_t     i_wdata,

    // Read ports.
    input  reg_addr_t i_raddr1,
    input  reg_addr_t i_raddr2,
    output word_t     o_rdata1,
    output word_t     o_rdata2
);

    // Entry 0 is never written, so x0 stays zero.
    word_t regs [ `NUM_REGS ];

    // Synchronous write, all entries cleared on reset.
    always_ff @( posedge i_clk ) begin
        if ( i_rst ) begin
            for ( int i = 0; i < `NUM_REGS; i++ ) begin
                regs[ i ] <= '0;
            end
        end else if ( i_we && ( i_waddr != '0 ) ) begin
            regs[ i_waddr ] <= i_wdata;
        end
    end

    // Asynchronous reads.
    // No bypass: same-cycle write shows up next cycle.
    assign o_rdata1 = regs[ i_raddr1 ];
    assign o_rdata2 = regs[ i_raddr2 ];

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ns
`include "rv64_consts.svh"

module decode_stage
    import rv64_isa_pkg::*;
    import decode_ctrl_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,

    // Fetch side, one-cycle strobe.
    input  instr_t      i_instr,
    input  logic        i_instr_valid,

    // Write-back port.
    input  logic        i_wb_we,
    input  reg_addr_t   i_wb_addr,
    input  word_t       i_wb_data,

    // Decode/execute register.
    output logic        o_valid,
    output word_t       o_imm_ext,
    output word_t       o_rs1_data,
    output word_t       o_rs2_data,
    output reg_addr_t   o_rd,
    output logic        o_reg_write,
    output logic        o_mem_write,
    output logic        o_branch,
    output logic        o_jump,
    output logic        o_illegal,
    output alu_src_t    o_alu_src,
    output result_src_t o_result_src,
    output alu_class_t  o_alu_class
);

    imm_fmt_t    imm_fmt;
    word_t       imm_ext;
    word_t       rs1_data;
    word_t       rs2_data;
    logic        reg_write;
    logic        mem_write;
    logic        branch;
    logic        jump;
    logic        illegal;
    alu_src_t    alu_src;
    result_src_t result_src;
    alu_class_t  alu_class;

    // ----------------------------------------
    // Combinational decode.
    // ----------------------------------------

    main_decoder u_main_decoder (
        .i_opcode     ( i_instr[ 6:0 ] ),
        .i_funct3     ( i_instr[ 14:12 ] ),
        .o_imm_fmt    ( imm_fmt ),
        .o_reg_write  ( reg_write ),
        .o_mem_write  ( mem_write ),
        .o_branch     ( branch ),
        .o_jump       ( jump ),
        .o_alu_src    ( alu_src ),
        .o_result_src ( result_src ),
        .o_alu_class  ( alu_class ),
        .o_illegal    ( illegal )
    );

    // Immediate field starts at bit 7.
    extend_imm u_extend_imm (
        .i_imm_fmt ( imm_fmt ),
        .i_imm     ( i_instr[ `IMM_FIELD_W + 6:7 ] ),
        .o_imm_ext ( imm_ext )
    );

    // rs1 at 19:15, rs2 at 24:20.
    register_file u_register_file (
        .i_clk    ( i_clk ),
        .i_rst    ( i_rst ),
        .i_we     ( i_wb_we ),
        .i_waddr  ( i_wb_addr ),
        .i_wdata  ( i_wb_data ),
        .i_raddr1 ( i_instr[ 19:15 ] ),
        .i_raddr2 ( i_instr[ 24:20 ] ),
        .o_rdata1 ( rs1_data ),
        .o_rdata2 ( rs2_data )
    );

    // ----------------------------------------
    // Pipeline register.
    // ----------------------------------------

    // Controls qualified by the strobe; idle cycles read as a bubble.
    always_ff @( posedge i_clk ) begin
        if ( i_rst || !i_instr_valid ) begin
            o_valid      <= 1'b0;
            o_reg_write  <= 1'b0;
            o_mem_write  <= 1'b0;
            o_branch     <= 1'b0;
            o_jump       <= 1'b0;
            o_illegal    <= 1'b0;
            o_alu_src    <= ALU_SRC_REG;
            o_result_src <= RES_ALU;
            o_alu_class  <= ALU_ADD;
        end else begin
            o_valid      <= 1'b1;
            o_reg_write  <= reg_write;
            o_mem_write  <= mem_write;
            o_branch     <= branch;
            o_jump       <= jump;
            o_illegal    <= illegal;
            o_alu_src    <= alu_src;
            o_result_src <= result_src;
            o_alu_class  <= alu_class;
        end
    end

    // Payload, held between strobes.
    always_ff @( posedge i_clk ) begin
        if ( i_instr_valid ) begin
            o_imm_ext  <= imm_ext;
            o_rs1_data <= rs1_data;
            o_rs2_data <= rs2_data;
            o_rd       <= i_instr[ 11:7 ];
        end
    end

endmodule

//--- tb/decode_stage_tb.sv
`timescale 1ns/1ns
`include "rv64_consts.svh"

module decode_stage_tb
    import rv64_isa_pkg::*;
    import decode_ctrl_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 20;

    logic        i_clk;
    logic        i_rst;
    instr_t      i_instr;
    logic        i_instr_valid;
    logic        i_wb_we;
    reg_addr_t   i_wb_addr;
    word_t       i_wb_data;
    logic        o_valid;
    word_t       o_imm_ext;
    word_t       o_rs1_data;
    word_t       o_rs2_data;
    reg_addr_t   o_rd;
    logic        o_reg_write;
    logic        o_mem_write;
    logic        o_branch;
    logic        o_jump;
    logic        o_illegal;
    alu_src_t    o_alu_src;
    result_src_t o_result_src;
    alu_class_t  o_alu_class;

    // Stimulus table with one entry per instruction.
    // Control word bits from the top are illegal, reg_write, mem_write, branch, jump,
    // alu_src, result_src[1:0] and alu_class[1:0].
    instr_t      tbl_instr[$];
    word_t       tbl_imm[$];
    logic        tbl_imm_chk[$];
    logic [9:0]  tbl_ctrl[$];
    reg_addr_t   tbl_rd[$];

    // Expected register contents where x0 stays zero.
    word_t       reg_model [`NUM_REGS];

    decode_stage UUT (
        .i_clk ( i_clk ), .i_rst ( i_rst ),
        .i_instr ( i_instr ), .i_instr_valid ( i_instr_valid ),
        .i_wb_we ( i_wb_we ), .i_wb_addr ( i_wb_addr ), .i_wb_data ( i_wb_data ),
        .o_valid ( o_valid ), .o_imm_ext ( o_imm_ext ),
        .o_rs1_data ( o_rs1_data ), .o_rs2_data ( o_rs2_data ), .o_rd ( o_rd ),
        .o_reg_write ( o_reg_write ), .o_mem_write ( o_mem_write ),
        .o_branch ( o_branch ), .o_jump ( o_jump ), .o_illegal ( o_illegal ),
        .o_alu_src ( o_alu_src ), .o_result_src ( o_result_src ),
        .o_alu_class ( o_alu_class )
    );

    // 4 ns clock.
    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // ----------------------------------------
    // Checking helpers.
    // ----------------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic add_entry(input instr_t instr, input word_t imm, input logic imm_chk,
                             input logic [9:0] ctrl, input reg_addr_t rd);
        tbl_instr.push_back(instr);
        tbl_imm.push_back(imm);
        tbl_imm_chk.push_back(imm_chk);
        tbl_ctrl.push_back(ctrl);
        tbl_rd.push_back(rd);
    endtask

    task automatic check_ctrl(input logic [9:0] exp);
        compare_value("o_illegal", 64'(o_illegal), 64'(exp[9]));
        compare_value("o_reg_write", 64'(o_reg_write), 64'(exp[8]));
        compare_value("o_mem_write", 64'(o_mem_write), 64'(exp[7]));
        compare_value("o_branch", 64'(o_branch), 64'(exp[6]));
        compare_value("o_jump", 64'(o_jump), 64'(exp[5]));
        compare_value("o_alu_src", 64'(o_alu_src), 64'(exp[4]));
        compare_value("o_result_src", 64'(o_result_src), 64'(exp[3:2]));
        compare_value("o_alu_class", 64'(o_alu_class), 64'(exp[1:0]));
    endtask

    // A bubble has o_valid and every control low.
    task automatic check_idle();
        compare_value("o_valid", 64'(o_valid), 64'(1'b0));
        check_ctrl(10'b0);
    endtask

    task automatic check_entry(input int k);
        compare_value("o_valid", 64'(o_valid), 64'(1'b1));
        compare_value("o_rd", 64'(o_rd), 64'(tbl_rd[k]));
        if (tbl_imm_chk[k]) begin
            compare_value("o_imm_ext", o_imm_ext, tbl_imm[k]);
        end
        compare_value("o_rs1_data", o_rs1_data, reg_model[tbl_instr[k][19:15]]);
        compare_value("o_rs2_data", o_rs2_data, reg_model[tbl_instr[k][24:20]]);
        check_ctrl(tbl_ctrl[k]);
    endtask

    // Result is due at the first falling edge after the strobe edge.
    task automatic wait_valid();
        int cycles;
        cycles = 0;
        while (!o_valid && cycles < TIMEOUT_CYCLES) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_valid) begin
            abort_run("Timed out waiting for o_valid after a strobe");
        end
        if (cycles != 0) begin
            abort_run($sformatf("o_valid arrived %0d cycles too late", cycles));
        end
    endtask

    // ----------------------------------------
    // Main sequence.
    // ----------------------------------------

    initial begin
        void'($urandom(32'h3622));
        i_rst         = 1'b1;
        i_instr       = '0;
        // A strobe held through reset must not reach the pipeline register.
        i_instr_valid = 1'b1;
        i_wb_we       = 1'b0;
        i_wb_addr     = '0;
        i_wb_data     = '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            reg_model[i] = '0;
        end

        // Negative I offset in ld x5, -8(x2).
        add_entry(32'hFF813283, 64'hFFFFFFFFFFFFFFF8, 1'b1, 10'b0_1_0_0_0_0_01_00, 5'd5);
        // Split S field in sd x7, -100(x3).
        add_entry(32'hF871BE23, 64'hFFFFFFFFFFFFFF9C, 1'b1, 10'b0_0_1_0_0_0_00_00, 5'd28);
        // B with bit 11 from instr[7] in bne x9, x10, +0xA54.
        add_entry(32'h24A49AE3, 64'h0000000000000A54, 1'b1, 10'b0_0_0_1_0_0_00_01, 5'd21);
        // Negative J offset.
        add_entry(32'hAABF00EF, 64'hFFFFFFFFFFFF0AAA, 1'b1, 10'b0_1_0_0_1_0_10_00, 5'd1);
        // jalr x0, 16(x1).
        add_entry(32'h01008067, 64'h0000000000000010, 1'b1, 10'b0_1_0_0_1_0_10_00, 5'd0);
        // LUI sign-extends the upper word.
        add_entry(32'h80001537, 64'hFFFFFFFF80001000, 1'b1, 10'b0_0_0_0_0_0_11_00, 5'd10);
        add_entry(32'h12345597, 64'h0000000012345000, 1'b1, 10'b0_0_0_0_0_0_00_00, 5'd11);
        // addi x5, x0, -1 reads rs1 as x0.
        add_entry(32'hFFF00293, 64'hFFFFFFFFFFFFFFFF, 1'b1, 10'b0_0_0_0_0_1_00_10, 5'd5);
        // add x3, x4, x5; R form has no immediate.
        add_entry(32'h005201B3, 64'h0, 1'b0, 10'b0_0_0_0_0_0_00_10, 5'd3);
        // csrrwi x6, 0xC00, 27; uimm zero-extended.
        add_entry(32'hC00DD373, 64'h000000000000001B, 1'b1, 10'b0_1_0_0_0_0_00_00, 5'd6);
        // Undefined opcode, then ecall.
        add_entry(32'hFFFFFFFF, 64'h0, 1'b0, 10'b1_0_0_0_0_0_00_00, 5'd31);
        add_entry(32'h00000073, 64'h0, 1'b0, 10'b1_0_0_0_0_0_00_00, 5'd0);

        repeat (2) @(negedge i_clk);
        i_rst         = 1'b0;
        i_instr_valid = 1'b0;
        check_idle();

        // Preload through write-back; the x0 write must be dropped.
        for (int i = 0; i < `NUM_REGS; i++) begin
            @(negedge i_clk);
            i_wb_we   = 1'b1;
            i_wb_addr = reg_addr_t'(i);
            i_wb_data = {$urandom, $urandom};
            if (i != 0) begin
                reg_model[i] = i_wb_data;
            end
        end
        @(negedge i_clk);
        i_wb_we = 1'b0;

        // Single strobes with an idle cycle after each.
        for (int k = 0; k < tbl_instr.size(); k++) begin
            @(negedge i_clk);
            i_instr       = tbl_instr[k];
            i_instr_valid = 1'b1;
            @(negedge i_clk);
            i_instr_valid = 1'b0;
            wait_valid();
            check_entry(k);
            @(negedge i_clk);
            check_idle();
        end

        // Back-to-back strobes; each result checked one cycle later.
        for (int k = 0; k <= tbl_instr.size(); k++) begin
            @(negedge i_clk);
            if (k > 0) begin
                check_entry(k - 1);
            end
            if (k < tbl_instr.size()) begin
                i_instr       = tbl_instr[k];
                i_instr_valid = 1'b1;
            end else begin
                i_instr_valid = 1'b0;
            end
        end
        @(negedge i_clk);
        check_idle();

        $display("Verification passed");
        $finish;
    end

endmodule

//--- decode_stage.f
+incdir+hdl
hdl/rv64_isa_pkg.sv
hdl/decode_ctrl_pkg.sv
hdl/extend_imm.sv
hdl/main_decoder.sv
hdl/register_file.sv
hdl/decode_stage.sv
tb/decode_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module decode_stage_tb -f decode_stage.f \
    -o decode_stage_sim \
    && ./obj_dir/decode_stage_sim | tee /dev/stderr | grep -q "Verification passed" \
    && exit 0 \
    || exit 1
